/* design/adc_capture_defines.svh */
`ifndef ADC_CAPTURE_DEFINES_SVH
`define ADC_CAPTURE_DEFINES_SVH

// ********************
// converter geometry
// ********************

// number of bits each lane returns per conversion
`define ADC_WORD_BITS 16

// the converter drives this many SDI lanes in parallel
`define ADC_LANES 2

// ********************
// serial timing
// ********************

// spi_clk cycles spent in each half of an SCLK period
// so one SCLK period takes twice this many cycles
`define SCLK_HALF_CYCLES 2

// width of the convert start pulse in spi_clk cycles
// the converter latches the request on the rising edge of convst
`define CONVST_CYCLES 4

`endif

/* design/adc_capture_pkg.sv */
`include "adc_capture_defines.svh"

package adc_capture_pkg;

    // ********************
    // data types
    // ********************

    // result of one conversion on a single lane
    typedef logic [`ADC_WORD_BITS-1:0] lane_word_t;

    // both lane results packed together
    // lane 1 sits in the upper half and lane 0 in the lower half
    typedef logic [`ADC_LANES*`ADC_WORD_BITS-1:0] sample_t;

    // position inside a frame, wide enough to hold the full word count
    typedef logic [$clog2(`ADC_WORD_BITS):0] bit_count_t;

    // ********************
    // sequencer states
    // ********************

    // IDLE waits for a start request
    // CONVST holds the convert pulse and WAIT_BUSY waits for the conversion
    // FRAME clocks the serial word out and DONE closes the frame
    typedef enum logic [2:0] {
        IDLE,
        CONVST,
        WAIT_BUSY,
        FRAME,
        DONE
    } seq_state_t;

endpackage

/* design/conv_sequencer.sv */
`timescale 1ns/10ps

`include "adc_capture_defines.svh"

module conv_sequencer (
    input  logic spi_clk,
    input  logic rst_n,
    input  logic start_valid,
    output logic start_ready,
    input  logic busy,
    output logic convst,
    output logic cs_n,
    output logic sclk,
    output logic bit_strobe,
    output logic frame_done
);

    import adc_capture_pkg::*;

    // spi_clk cycles in one full SCLK period
    localparam int SCLK_PERIOD = 2 * `SCLK_HALF_CYCLES;

    seq_state_t state;

    // shared cycle counter, times the convst pulse and then the SCLK phase
    logic [7:0] phase;

    // index of the bit currently on the wire
    bit_count_t bit_cnt;

    // high on the final spi_clk cycle of an SCLK period
    logic period_end;

    // high on the final cycle of the convert pulse
    logic convst_end;

    // ********************
    // output decode
    // ********************

    // a new request is only taken while nothing is in flight
    assign start_ready = (state == IDLE);

    // the convert pulse spans the whole CONVST state
    assign convst = (state == CONVST);

    // chip select is active for the serial frame only
    assign cs_n = (state != FRAME);

    // SCLK idles low, goes high for the second half of each period
    assign sclk = (state == FRAME) && (phase >= `SCLK_HALF_CYCLES);

    // sample point is the cycle where SCLK rises
    // the ADC changed its data on the previous falling edge so SDI is settled
    assign bit_strobe = (state == FRAME) && (phase == `SCLK_HALF_CYCLES);

    // cs_n rises on this same cycle
    assign frame_done = (state == DONE);

    assign period_end = (phase == SCLK_PERIOD - 1);
    assign convst_end = (phase == `CONVST_CYCLES - 1);

    // ********************
    // state machine
    // ********************

    always_ff @(posedge spi_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            phase   <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // convst goes high on the cycle after acceptance
                    if (start_valid) begin
                        state <= CONVST;
                        phase <= '0;
                    end
                end
                CONVST: begin
                    if (convst_end) begin
                        state <= WAIT_BUSY;
                        phase <= '0;
                    end else begin
                        phase <= phase + 8'd1;
                    end
                end
                WAIT_BUSY: begin
                    // conversion is finished once busy drops
                    if (!busy) begin
                        state   <= FRAME;
                        phase   <= '0;
                        bit_cnt <= '0;
                    end
                end
                FRAME: begin
                    if (period_end) begin
                        phase <= '0;
                        // after the last period the frame closes
                        if (bit_cnt == `ADC_WORD_BITS - 1) begin
                            state <= DONE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        phase <= phase + 8'd1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ********************
    // checks
    // ********************

    // the ADC must have finished converting before the frame is opened
    assert property (@(posedge spi_clk) disable iff (!rst_n) !cs_n |-> !busy);

    // the convert pulse stays up for exactly CONVST_CYCLES cycles
    assert property (@(posedge spi_clk) disable iff (!rst_n)
        $rose(convst) |-> ##`CONVST_CYCLES $fell(convst));

endmodule

/* design/sdi_lane_shifter.sv */
`timescale 1ns/10ps

`include "adc_capture_defines.svh"

module sdi_lane_shifter (
    input  logic                      spi_clk,
    input  logic                      rst_n,
    input  logic                      bit_strobe,
    input  logic                      frame_done,
    input  logic                      sdi,
    output adc_capture_pkg::lane_word_t lane_word
);

    import adc_capture_pkg::*;

    // received bits, MSB arrives first and ends up at the top
    lane_word_t shift_q;

    // strobes seen since the last frame_done
    bit_count_t strobe_cnt;

    // ********************
    // data path
    // ********************

    // payload register, holds whatever was last shifted in
    always_ff @(posedge spi_clk) begin
        if (bit_strobe) begin
            shift_q <= {shift_q[`ADC_WORD_BITS-2:0], sdi};
        end
    end

    // after the last strobe the register already holds the full word
    // so it is valid on the frame_done cycle
    assign lane_word = shift_q;

    // ********************
    // frame length tracking
    // ********************

    always_ff @(posedge spi_clk or negedge rst_n) begin
        if (!rst_n) begin
            strobe_cnt <= '0;
        end else if (frame_done) begin
            strobe_cnt <= '0;
        end else if (bit_strobe) begin
            strobe_cnt <= strobe_cnt + 1'b1;
        end
    end

    // the sequencer must deliver exactly one word of strobes per frame
    assert property (@(posedge spi_clk) disable iff (!rst_n)
        frame_done |-> (strobe_cnt == `ADC_WORD_BITS));

    // no strobe may arrive once the word is full and the frame is still open
    assert property (@(posedge spi_clk) disable iff (!rst_n)
        bit_strobe |-> (strobe_cnt < `ADC_WORD_BITS));

endmodule

/* design/sample_merge.sv */
`timescale 1ns/10ps

module sample_merge (
    input  logic                        spi_clk,
    input  logic                        rst_n,
    input  logic                        frame_done,
    input  adc_capture_pkg::lane_word_t lane0_word,
    input  adc_capture_pkg::lane_word_t lane1_word,
    output logic                        sample_valid,
    output adc_capture_pkg::sample_t    sample_data,
    input  logic                        sample_ready,
    output logic                        irq
);

    import adc_capture_pkg::*;

    // two entry sample buffer, payload only
    sample_t mem [2];

    // pointers carry one extra wrap bit to tell full from empty
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;

    logic empty;
    logic full;
    logic push;
    logic pop;
    logic drop;

    // lane 1 goes to the upper half
    sample_t packed_sample;

    // ********************
    // buffer status
    // ********************

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[1] != rd_ptr[1]) && (wr_ptr[0] == rd_ptr[0]);

    assign pop = sample_valid && sample_ready;

    // a read on the same cycle frees a slot, so the sample still fits
    assign push = frame_done && (!full || pop);

    // everything else arriving on a full buffer is lost
    assign drop = frame_done && full && !pop;

    assign packed_sample = {lane1_word, lane0_word};

    // ********************
    // storage
    // ********************

    always_ff @(posedge spi_clk) begin
        if (push) begin
            mem[wr_ptr[0]] <= packed_sample;
        end
    end

    always_ff @(posedge spi_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            irq    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            // frame_done lasts a single cycle so irq does too
            irq <= drop;
        end
    end

    // ********************
    // output side
    // ********************

    // valid follows the registered pointers, one cycle after frame_done
    assign sample_valid = !empty;
    assign sample_data  = mem[rd_ptr[0]];

    // a stalled sample must not change under the consumer
    assert property (@(posedge spi_clk) disable iff (!rst_n)
        (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample_data)));

endmodule

/* design/adc_capture_top.sv */
`timescale 1ns/10ps

`include "adc_capture_defines.svh"

module adc_capture_top (
    input  logic                     spi_clk,
    input  logic                     rst_n,
    input  logic                     start_valid,
    output logic                     start_ready,
    output logic                     convst,
    input  logic                     busy,
    output logic                     cs_n,
    output logic                     sclk,
    output logic                     sdo,
    input  logic [`ADC_LANES-1:0]    sdi,
    output logic                     sample_valid,
    output adc_capture_pkg::sample_t sample_data,
    input  logic                     sample_ready,
    output logic                     irq
);

    import adc_capture_pkg::*;

    // timing shared by both lanes
    logic bit_strobe;
    logic frame_done;

    // one finished word per lane
    lane_word_t lane0_word;
    lane_word_t lane1_word;

    // nothing is written to the converter, the line stays low
    assign sdo = 1'b0;

    // ********************
    // control
    // ********************

    conv_sequencer i_sequencer (
        .spi_clk     (spi_clk),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .busy        (busy),
        .convst      (convst),
        .cs_n        (cs_n),
        .sclk        (sclk),
        .bit_strobe  (bit_strobe),
        .frame_done  (frame_done)
    );

    // ********************
    // lanes
    // ********************

    // both lanes sample on the same strobe
    sdi_lane_shifter i_lane0 (
        .spi_clk    (spi_clk),
        .rst_n      (rst_n),
        .bit_strobe (bit_strobe),
        .frame_done (frame_done),
        .sdi        (sdi[0]),
        .lane_word  (lane0_word)
    );

    sdi_lane_shifter i_lane1 (
        .spi_clk    (spi_clk),
        .rst_n      (rst_n),
        .bit_strobe (bit_strobe),
        .frame_done (frame_done),
        .sdi        (sdi[1]),
        .lane_word  (lane1_word)
    );

    // ********************
    // output buffer
    // ********************

    sample_merge i_merge (
        .spi_clk      (spi_clk),
        .rst_n        (rst_n),
        .frame_done   (frame_done),
        .lane0_word   (lane0_word),
        .lane1_word   (lane1_word),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .irq          (irq)
    );

endmodule

/* test/adc_model.sv */
`timescale 1ns/10ps

`include "adc_capture_defines.svh"

module adc_model (
    input  logic                  spi_clk,
    input  logic                  rst_n,
    input  logic                  convst,
    output logic                  busy,
    input  logic                  cs_n,
    input  logic                  sclk,
    output logic [`ADC_LANES-1:0] sdi
);

    import adc_capture_pkg::*;

    // words the testbench has queued up for the next conversion
    lane_word_t next_word0 = '0;
    lane_word_t next_word1 = '0;

    // words frozen when the convert pulse starts
    lane_word_t conv_word0;
    lane_word_t conv_word1;

    // how long busy stays up after each convert request
    int busy_cycles = 1;
    int busy_left;

    logic convst_q;

    // bit currently presented on both lanes, MSB first
    int bit_idx = 0;

    // ********************
    // testbench access
    // ********************

    task load_words(input lane_word_t w0, input lane_word_t w1);
        next_word0 = w0;
        next_word1 = w1;
    endtask

    task set_busy_cycles(input int cycles);
        busy_cycles = cycles;
    endtask

    // ********************
    // conversion timing
    // ********************

    // busy rises on the first cycle convst is seen high, so the sequencer
    // already finds it set when it starts waiting
    always @(posedge spi_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            busy_left  <= 0;
            convst_q   <= 1'b0;
            conv_word0 <= '0;
            conv_word1 <= '0;
        end else begin
            convst_q <= convst;
            if (convst && !convst_q) begin
                conv_word0 <= next_word0;
                conv_word1 <= next_word1;
                busy       <= (busy_cycles > 0);
                busy_left  <= busy_cycles;
            end else if (busy_left > 1) begin
                busy_left <= busy_left - 1;
            end else begin
                busy_left <= 0;
                busy      <= 1'b0;
            end
        end
    end

    // ********************
    // serial output
    // ********************

    // the MSB goes out as soon as the frame opens
    always @(negedge cs_n) begin
        bit_idx = `ADC_WORD_BITS - 1;
    end

    // data moves on to the next bit on every falling SCLK
    always @(negedge sclk) begin
        if (!cs_n && bit_idx > 0) begin
            bit_idx = bit_idx - 1;
        end
    end

    assign sdi = {conv_word1[bit_idx], conv_word0[bit_idx]};

endmodule

/* test/system_tb.sv */
`timescale 1ns/10ps

`include "adc_capture_defines.svh"

module system_tb;

    import adc_capture_pkg::*;

    localparam int NUM_ROWS = 10;
    localparam int B2B_COUNT = 3;
    localparam int B2B_BUSY = 8;
    localparam int STALL_CYCLES = 4;
    localparam logic [31:0] LFSR_SEED = 32'h11e2_f470;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                  spi_clk;
    logic                  rst_n;
    logic                  start_valid;
    logic                  start_ready;
    logic                  convst;
    logic                  busy;
    logic                  cs_n;
    logic                  sclk;
    logic                  sdo;
    logic [`ADC_LANES-1:0] sdi;
    logic                  sample_valid;
    sample_t               sample_data;
    logic                  sample_ready;
    logic                  irq;

    // stimulus table, one conversion per row
    // hold keeps sample_ready low after the row so samples pile up
    lane_word_t row_w0 [NUM_ROWS];
    lane_word_t row_w1 [NUM_ROWS];
    int         row_busy [NUM_ROWS];
    logic       row_hold [NUM_ROWS];

    lane_word_t b2b_w0;
    lane_word_t b2b_w1;

    // samples the output buffer should be holding, oldest first
    sample_t exp_q [$];

    logic [31:0] lfsr_state;
    logic        convst_prev = 1'b0;

    int mismatch_count = 0;
    int failure_count = 0;
    int cycle_count = 0;
    int timeout_limit = 0;
    int accept_count = 0;
    int convst_pulses = 0;
    int irq_pulses = 0;
    int irq_run = 0;
    int exp_drops = 0;

    adc_capture_top uut (
        .spi_clk      (spi_clk),
        .rst_n        (rst_n),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .convst       (convst),
        .busy         (busy),
        .cs_n         (cs_n),
        .sclk         (sclk),
        .sdo          (sdo),
        .sdi          (sdi),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .irq          (irq)
    );

    adc_model i_adc (
        .spi_clk (spi_clk),
        .rst_n   (rst_n),
        .convst  (convst),
        .busy    (busy),
        .cs_n    (cs_n),
        .sclk    (sclk),
        .sdi     (sdi)
    );

    initial begin
        spi_clk = 1'b0;
        forever #20 spi_clk = ~spi_clk;
    end

    // ********************
    // random source
    // ********************

    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    // one LFSR step for every bit taken
    function automatic logic [15:0] random_bits(input int count);
        logic [15:0] value;
        int          k;
        value = '0;
        for (k = 0; k < count; k++) begin
            value = {value[14:0], next_random_bit()};
        end
        return value;
    endfunction

    // ********************
    // compare tasks
    // ********************

    task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input lane_word_t expected,
                              input lane_word_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_irq(input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: irq expected %b got %b", $time, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // ********************
    // monitors
    // ********************

    // every monitor sees the values from just before the clock edge
    always @(posedge spi_clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    always @(posedge spi_clk) begin
        if (rst_n) begin
            if (!cs_n && busy) begin
                failure_count++;
                $display("%0t: chip select went low while the ADC still reported busy", $time);
            end
            // nothing is ever written to the converter
            check_flag("sdo", 1'b0, sdo);
            if (start_valid && start_ready) begin
                accept_count++;
            end
            if (convst && !convst_prev) begin
                convst_pulses++;
            end
            convst_prev = convst;
            // irq must fall again right after one cycle
            if (irq) begin
                irq_run++;
            end else if (irq_run > 0) begin
                if (irq_run != 1) begin
                    failure_count++;
                    $display("%0t: irq stayed high for %0d cycles", $time, irq_run);
                end
                irq_pulses++;
                irq_run = 0;
            end
        end
    end

    // ********************
    // stimulus
    // ********************

    task next_cycle();
        @(posedge spi_clk);
        #2;
    endtask

    task fill_table();
        int r;
        lfsr_state = LFSR_SEED;
        row_w0[0] = 16'hA5C3;
        row_w1[0] = 16'h3C5A;
        row_busy[0] = 6;
        row_hold[0] = 1'b0;
        for (r = 1; r < 6; r++) begin
            row_w0[r] = random_bits(16);
            row_w1[r] = random_bits(16);
            row_busy[r] = 2 + int'(random_bits(5));
            row_hold[r] = 1'b0;
        end
        // three conversions into a stalled output, the last one is lost
        row_w0[6] = 16'h1234;
        row_w1[6] = 16'hABCD;
        row_busy[6] = 10;
        row_hold[6] = 1'b1;
        row_w0[7] = 16'h0F0F;
        row_w1[7] = 16'hF0F0;
        row_busy[7] = 3;
        row_hold[7] = 1'b1;
        row_w0[8] = 16'hDEAD;
        row_w1[8] = 16'hBEEF;
        row_busy[8] = 20;
        row_hold[8] = 1'b0;
        row_w0[9] = random_bits(16);
        row_w1[9] = random_bits(16);
        row_busy[9] = 2 + int'(random_bits(5));
        row_hold[9] = 1'b0;
        b2b_w0 = random_bits(16);
        b2b_w1 = random_bits(16);
    endtask

    function automatic int timeout_cycles();
        int total;
        int r;
        total = 200 + B2B_COUNT * (B2B_BUSY + 80);
        for (r = 0; r < NUM_ROWS; r++) begin
            total += row_busy[r] + 80;
        end
        return total;
    endfunction

    task check_idle_outputs();
        check_flag("convst", 1'b0, convst);
        check_flag("sclk", 1'b0, sclk);
        check_irq(1'b0, irq);
        check_flag("sample_valid", 1'b0, sample_valid);
        check_flag("cs_n", 1'b1, cs_n);
        check_flag("start_ready", 1'b1, start_ready);
    endtask

    task run_conversion(input int row);
        logic exp_drop;
        i_adc.load_words(row_w0[row], row_w1[row]);
        i_adc.set_busy_cycles(row_busy[row]);
        check_flag("start_ready", 1'b1, start_ready);
        start_valid = 1'b1;
        next_cycle();
        start_valid = 1'b0;
        // start_ready comes back on the same edge the sample is stored
        while (!start_ready) begin
            next_cycle();
        end
        exp_drop = (exp_q.size() == 2);
        if (exp_drop) begin
            exp_drops++;
        end else begin
            exp_q.push_back({row_w1[row], row_w0[row]});
        end
        check_irq(exp_drop, irq);
        if (row == 0) begin
            check_word("lane0 word", row_w0[0], sample_data[`ADC_WORD_BITS-1:0]);
            check_word("lane1 word", row_w1[0],
                       sample_data[2*`ADC_WORD_BITS-1:`ADC_WORD_BITS]);
        end
        next_cycle();
        check_irq(1'b0, irq);
    endtask

    task drain_samples();
        logic lost;
        lost = 1'b0;
        // a waiting sample must hold still while ready is low
        if (exp_q.size() > 0) begin
            repeat (STALL_CYCLES) begin
                check_flag("sample_valid", 1'b1, sample_valid);
                check_sample("sample_data", exp_q[0], sample_data);
                next_cycle();
            end
        end
        while (exp_q.size() > 0 && !lost) begin
            if (!sample_valid) begin
                failure_count++;
                $display("%0t: sample_valid fell with %0d samples still expected",
                         $time, exp_q.size());
                lost = 1'b1;
            end else begin
                check_sample("sample_data", exp_q[0], sample_data);
                void'(exp_q.pop_front());
                sample_ready = 1'b1;
                next_cycle();
            end
        end
        exp_q.delete();
        sample_ready = 1'b0;
        if (sample_valid) begin
            failure_count++;
            $display("%0t: an extra sample is present after the buffer drained", $time);
        end
    endtask

    task run_back_to_back();
        int accept_base;
        int seen;
        accept_base = accept_count;
        seen = 0;
        i_adc.load_words(b2b_w0, b2b_w1);
        i_adc.set_busy_cycles(B2B_BUSY);
        sample_ready = 1'b1;
        start_valid = 1'b1;
        while (seen < B2B_COUNT) begin
            if (accept_count - accept_base >= B2B_COUNT) begin
                start_valid = 1'b0;
            end
            // with ready high each sample is offered for one cycle
            if (sample_valid) begin
                check_sample("sample_data", {b2b_w1, b2b_w0}, sample_data);
                seen++;
            end
            next_cycle();
        end
        start_valid = 1'b0;
        repeat (8) begin
            if (sample_valid) begin
                failure_count++;
                $display("%0t: a sample appeared without a matching start request", $time);
            end
            next_cycle();
        end
        sample_ready = 1'b0;
        if (accept_count - accept_base != B2B_COUNT) begin
            failure_count++;
            $display("back-to-back phase accepted %0d start requests instead of %0d",
                     accept_count - accept_base, B2B_COUNT);
        end
        check_flag("start_ready", 1'b1, start_ready);
    endtask

    // ********************
    // main sequence
    // ********************

    initial begin
        int i;
        rst_n = 1'b0;
        start_valid = 1'b0;
        sample_ready = 1'b0;
        fill_table();
        timeout_limit = timeout_cycles();
        repeat (2) @(posedge spi_clk);
        #2;
        check_idle_outputs();
        rst_n = 1'b1;
        next_cycle();
        check_idle_outputs();
        for (i = 0; i < NUM_ROWS; i++) begin
            run_conversion(i);
            if (!row_hold[i]) begin
                drain_samples();
            end
        end
        drain_samples();
        run_back_to_back();
        if (accept_count != NUM_ROWS + B2B_COUNT) begin
            failure_count++;
            $display("saw %0d accepted start requests, expected %0d",
                     accept_count, NUM_ROWS + B2B_COUNT);
        end
        if (convst_pulses != accept_count) begin
            failure_count++;
            $display("convst pulsed %0d times for %0d accepted requests",
                     convst_pulses, accept_count);
        end
        if (irq_pulses != exp_drops) begin
            failure_count++;
            $display("irq pulsed %0d times but %0d samples were dropped", irq_pulses, exp_drops);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+design
design/adc_capture_pkg.sv
design/conv_sequencer.sv
design/sdi_lane_shifter.sv
design/sample_merge.sv
design/adc_capture_top.sv
test/adc_model.sv
test/system_tb.sv
